// ==== hw/div_config.svh ====
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define DIV_WIDTH      32
`define DIV_TAG_WIDTH  8
`define DIV_PC_WIDTH   32
`define DIV_OP_WIDTH   4

// one array stage per quotient bit
`define DIV_STAGES     `DIV_WIDTH

`endif

// ==== hw/div_pkg.sv ====
`include "div_config.svh"

package div_pkg;

    // ------------------------------
    // width types
    // ------------------------------
    typedef logic [`DIV_WIDTH-1:0]     div_data_t;  // operand, quotient, remainder
    typedef logic [`DIV_TAG_WIDTH-1:0] div_tag_t;   // physical dest register
    typedef logic [`DIV_PC_WIDTH-1:0]  div_pc_t;

    // ------------------------------
    // divide opcodes
    // ------------------------------
    // unlisted codes decode as divu
    typedef enum logic [`DIV_OP_WIDTH-1:0] {
        DIV_OP_DIV  = 1,
        DIV_OP_DIVU = 2,
        DIV_OP_REM  = 3,
        DIV_OP_REMU = 4
    } div_op_e;

endpackage

// ==== hw/div_operand_prep.sv ====
`include "div_config.svh"

module div_operand_prep import div_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  div_data_t a,
    input  div_data_t b,
    input  div_op_e   div_op,
    input  div_tag_t  tag_in,
    input  div_pc_t   pc_in,
    output logic      prep_valid,
    output div_data_t dividend_mag,
    output div_data_t divisor_mag,
    output div_data_t dividend_raw,
    output logic      want_rem,
    output logic      negate_res,
    output logic      div_by_zero,
    output div_tag_t  tag,
    output div_pc_t   pc
);

    logic is_signed;
    logic is_rem;
    logic a_neg;
    logic b_neg;
    logic b_zero;

    // ------------------------------
    // opcode decode
    // ------------------------------
    always_comb begin
        case (div_op)
            DIV_OP_DIV: begin
                is_signed = 1'b1;
                is_rem    = 1'b0;
            end
            DIV_OP_REM: begin
                is_signed = 1'b1;
                is_rem    = 1'b1;
            end
            DIV_OP_REMU: begin
                is_signed = 1'b0;
                is_rem    = 1'b1;
            end
            default: begin // divu and anything unknown
                is_signed = 1'b0;
                is_rem    = 1'b0;
            end
        endcase
    end

    assign a_neg  = is_signed & a[`DIV_WIDTH-1];
    assign b_neg  = is_signed & b[`DIV_WIDTH-1];
    assign b_zero = (b == '0);

    // ------------------------------
    // request register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            prep_valid   <= 1'b0;
            dividend_mag <= '0;
            divisor_mag  <= '0;
            dividend_raw <= '0;
            want_rem     <= 1'b0;
            negate_res   <= 1'b0;
            div_by_zero  <= 1'b0;
            tag          <= '0;
            pc           <= '0;
        end else begin
            prep_valid   <= start;
            dividend_mag <= a_neg ? -a : a;  // min int stays 0x8000_0000
            divisor_mag  <= b_neg ? -b : b;
            dividend_raw <= a;
            want_rem     <= is_rem;
            // remainder takes the dividend sign
            negate_res   <= !b_zero && (is_rem ? a_neg : (a_neg ^ b_neg));
            div_by_zero  <= b_zero;
            tag          <= tag_in;
            pc           <= pc_in;
        end
    end

endmodule

// ==== hw/div_restoring_array.sv ====
`include "div_config.svh"

module div_restoring_array import div_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      prep_valid,
    input  div_data_t dividend_mag,
    input  div_data_t divisor_mag,
    input  div_data_t dividend_raw,
    input  logic      want_rem,
    input  logic      negate_res,
    input  logic      div_by_zero,
    input  div_tag_t  tag,
    input  div_pc_t   pc,
    output logic      arr_valid,
    output div_data_t quotient,
    output div_data_t remainder,
    output div_data_t arr_dividend_raw,
    output logic      arr_want_rem,
    output logic      arr_negate_res,
    output logic      arr_div_by_zero,
    output div_tag_t  arr_tag,
    output div_pc_t   arr_pc
);

    // ------------------------------
    // stage registers
    // ------------------------------
    logic      stg_valid [`DIV_STAGES];
    div_data_t stg_rem   [`DIV_STAGES];  // partial remainder
    div_data_t stg_quo   [`DIV_STAGES];  // dividend bits out, quotient bits in
    div_data_t stg_dsr   [`DIV_STAGES];
    div_data_t stg_raw   [`DIV_STAGES];
    logic      stg_wrem  [`DIV_STAGES];
    logic      stg_neg   [`DIV_STAGES];
    logic      stg_dbz   [`DIV_STAGES];
    div_tag_t  stg_tag   [`DIV_STAGES];
    div_pc_t   stg_pc    [`DIV_STAGES];

    // one restoring step giving {remainder, quotient}
    function automatic logic [2*`DIV_WIDTH-1:0] div_step(
        input div_data_t rem_in,
        input div_data_t quo_in,
        input div_data_t dsr
    );
        logic [`DIV_WIDTH:0] trial;
        logic [`DIV_WIDTH:0] diff;
        logic                take;
        trial = {rem_in, quo_in[`DIV_WIDTH-1]};  // bring down next dividend bit
        diff  = trial - {1'b0, dsr};
        take  = (trial >= {1'b0, dsr});
        if (take) begin
            div_step = {diff[`DIV_WIDTH-1:0], quo_in[`DIV_WIDTH-2:0], 1'b1};
        end else begin
            div_step = {trial[`DIV_WIDTH-1:0], quo_in[`DIV_WIDTH-2:0], 1'b0};
        end
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DIV_STAGES; i++) begin
                stg_valid[i] <= 1'b0;
                stg_rem[i]   <= '0;
                stg_quo[i]   <= '0;
                stg_dsr[i]   <= '0;
                stg_raw[i]   <= '0;
                stg_wrem[i]  <= 1'b0;
                stg_neg[i]   <= 1'b0;
                stg_dbz[i]   <= 1'b0;
                stg_tag[i]   <= '0;
                stg_pc[i]    <= '0;
            end
        end else begin
            // first stage starts from a zero remainder
            stg_valid[0] <= prep_valid;
            {stg_rem[0], stg_quo[0]} <= div_step('0, dividend_mag, divisor_mag);
            stg_dsr[0]   <= divisor_mag;
            stg_raw[0]   <= dividend_raw;
            stg_wrem[0]  <= want_rem;
            stg_neg[0]   <= negate_res;
            stg_dbz[0]   <= div_by_zero;
            stg_tag[0]   <= tag;
            stg_pc[0]    <= pc;

            for (int i = 1; i < `DIV_STAGES; i++) begin
                stg_valid[i] <= stg_valid[i-1];
                {stg_rem[i], stg_quo[i]} <= div_step(stg_rem[i-1], stg_quo[i-1], stg_dsr[i-1]);
                stg_dsr[i]   <= stg_dsr[i-1];
                stg_raw[i]   <= stg_raw[i-1];
                stg_wrem[i]  <= stg_wrem[i-1];
                stg_neg[i]   <= stg_neg[i-1];
                stg_dbz[i]   <= stg_dbz[i-1];
                stg_tag[i]   <= stg_tag[i-1];
                stg_pc[i]    <= stg_pc[i-1];
            end
        end
    end

    // ------------------------------
    // last stage holds the answer
    // ------------------------------
    assign arr_valid        = stg_valid[`DIV_STAGES-1];
    assign quotient         = stg_quo[`DIV_STAGES-1];
    assign remainder        = stg_rem[`DIV_STAGES-1];
    assign arr_dividend_raw = stg_raw[`DIV_STAGES-1];
    assign arr_want_rem     = stg_wrem[`DIV_STAGES-1];
    assign arr_negate_res   = stg_neg[`DIV_STAGES-1];
    assign arr_div_by_zero  = stg_dbz[`DIV_STAGES-1];
    assign arr_tag          = stg_tag[`DIV_STAGES-1];
    assign arr_pc           = stg_pc[`DIV_STAGES-1];

endmodule

// ==== hw/div_result_fixup.sv ====
module div_result_fixup import div_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      arr_valid,
    input  div_data_t quotient,
    input  div_data_t remainder,
    input  div_data_t arr_dividend_raw,
    input  logic      arr_want_rem,
    input  logic      arr_negate_res,
    input  logic      arr_div_by_zero,
    input  div_tag_t  arr_tag,
    input  div_pc_t   arr_pc,
    output div_data_t result,
    output logic      done,
    output div_tag_t  tag_out,
    output div_pc_t   pc_out
);

    div_data_t mag_sel;
    div_data_t signed_res;
    div_data_t final_res;

    // ------------------------------
    // select, sign, zero rule
    // ------------------------------
    assign mag_sel    = arr_want_rem ? remainder : quotient;
    assign signed_res = arr_negate_res ? -mag_sel : mag_sel;

    always_comb begin
        if (arr_div_by_zero) begin
            // rem returns dividend, div returns all ones
            final_res = arr_want_rem ? arr_dividend_raw : '1;
        end else begin
            final_res = signed_res;
        end
    end

    // ------------------------------
    // writeback register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            result  <= '0;
            done    <= 1'b0;
            tag_out <= '0;
            pc_out  <= '0;
        end else begin
            result  <= final_res;
            done    <= arr_valid;  // one pulse per request
            tag_out <= arr_tag;
            pc_out  <= arr_pc;
        end
    end

endmodule

// ==== hw/div_unit.sv ====
module div_unit import div_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  div_data_t a,
    input  div_data_t b,
    input  div_op_e   div_op,
    input  div_tag_t  tag_in,
    input  div_pc_t   pc_in,
    output div_data_t result,
    output logic      done,
    output div_tag_t  tag_out,
    output div_pc_t   pc_out
);

    // prep -> array
    logic      prep_valid;
    div_data_t dividend_mag;
    div_data_t divisor_mag;
    div_data_t dividend_raw;
    logic      want_rem;
    logic      negate_res;
    logic      div_by_zero;
    div_tag_t  tag;
    div_pc_t   pc;

    // array -> fixup
    logic      arr_valid;
    div_data_t quotient;
    div_data_t remainder;
    div_data_t arr_dividend_raw;
    logic      arr_want_rem;
    logic      arr_negate_res;
    logic      arr_div_by_zero;
    div_tag_t  arr_tag;
    div_pc_t   arr_pc;

    div_operand_prep u_prep (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .a            (a),
        .b            (b),
        .div_op       (div_op),
        .tag_in       (tag_in),
        .pc_in        (pc_in),
        .prep_valid   (prep_valid),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .dividend_raw (dividend_raw),
        .want_rem     (want_rem),
        .negate_res   (negate_res),
        .div_by_zero  (div_by_zero),
        .tag          (tag),
        .pc           (pc)
    );

    div_restoring_array u_array (
        .clk              (clk),
        .reset            (reset),
        .prep_valid       (prep_valid),
        .dividend_mag     (dividend_mag),
        .divisor_mag      (divisor_mag),
        .dividend_raw     (dividend_raw),
        .want_rem         (want_rem),
        .negate_res       (negate_res),
        .div_by_zero      (div_by_zero),
        .tag              (tag),
        .pc               (pc),
        .arr_valid        (arr_valid),
        .quotient         (quotient),
        .remainder        (remainder),
        .arr_dividend_raw (arr_dividend_raw),
        .arr_want_rem     (arr_want_rem),
        .arr_negate_res   (arr_negate_res),
        .arr_div_by_zero  (arr_div_by_zero),
        .arr_tag          (arr_tag),
        .arr_pc           (arr_pc)
    );

    div_result_fixup u_fixup (
        .clk              (clk),
        .reset            (reset),
        .arr_valid        (arr_valid),
        .quotient         (quotient),
        .remainder        (remainder),
        .arr_dividend_raw (arr_dividend_raw),
        .arr_want_rem     (arr_want_rem),
        .arr_negate_res   (arr_negate_res),
        .arr_div_by_zero  (arr_div_by_zero),
        .arr_tag          (arr_tag),
        .arr_pc           (arr_pc),
        .result           (result),
        .done             (done),
        .tag_out          (tag_out),
        .pc_out           (pc_out)
    );

endmodule

// ==== verification/div_unit_tb.sv ====
`include "div_config.svh"

module div_unit_tb import div_pkg::*; ();

    localparam int NUM_VECS    = 31;
    localparam int REC_W       = `DIV_OP_WIDTH + 3*`DIV_WIDTH + `DIV_TAG_WIDTH + `DIV_PC_WIDTH;
    localparam int LATENCY     = 34;  // edges from drive slot to done
    localparam int DRAIN_LIMIT = 120;
    localparam int IDLE_CHECK  = 40;

    // index ranges in the golden file
    localparam int UNS_FIRST = 0;
    localparam int UNS_LAST  = 11;
    localparam int SGN_FIRST = 12;
    localparam int SGN_LAST  = 24;
    localparam int DBZ_FIRST = 25;
    localparam int DBZ_LAST  = 30;

    logic      clk;
    logic      reset;
    logic      start;
    div_data_t a;
    div_data_t b;
    div_op_e   div_op;
    div_tag_t  tag_in;
    div_pc_t   pc_in;
    div_data_t result;
    logic      done;
    div_tag_t  tag_out;
    div_pc_t   pc_out;

    logic [REC_W-1:0] golden_mem [NUM_VECS];

    // expected results in issue order
    div_data_t   exp_res_q [$];
    div_tag_t    exp_tag_q [$];
    div_pc_t     exp_pc_q  [$];
    int unsigned exp_cyc_q [$];

    int unsigned cycle_cnt;
    int          err_count;
    int          check_count;
    int          done_count;
    int unsigned seed;
    int unsigned gap;

    div_unit DUT (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .a       (a),
        .b       (b),
        .div_op  (div_op),
        .tag_in  (tag_in),
        .pc_in   (pc_in),
        .result  (result),
        .done    (done),
        .tag_out (tag_out),
        .pc_out  (pc_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // ------------------------------
    // result monitor
    // ------------------------------
    always @(negedge clk) begin
        if (!reset && done === 1'b1) begin
            done_count++;
            if (exp_tag_q.size() == 0) begin
                err_count++;
                $display("done pulse at cycle %0d with no request outstanding", cycle_cnt);
            end else begin
                compare_value("result", result, exp_res_q.pop_front());
                compare_value("tag_out", tag_out, exp_tag_q.pop_front());
                compare_value("pc_out", pc_out, exp_pc_q.pop_front());
                compare_value("done latency", cycle_cnt - exp_cyc_q.pop_front(), LATENCY);
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic send_vector(input int idx);
        logic [`DIV_OP_WIDTH-1:0] op;
        div_data_t                av;
        div_data_t                bv;
        div_tag_t                 tv;
        div_pc_t                  pv;
        div_data_t                ev;
        {op, av, bv, tv, pv, ev} = golden_mem[idx];
        @(posedge clk);
        #1;
        start  = 1'b1;
        div_op = div_op_e'(op);
        a      = av;
        b      = bv;
        tag_in = tv;
        pc_in  = pv;
        exp_res_q.push_back(ev);
        exp_tag_q.push_back(tv);
        exp_pc_q.push_back(pv);
        exp_cyc_q.push_back(cycle_cnt);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            start = 1'b0;
        end
    endtask

    task automatic send_range(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            send_vector(i);  // back to back
        end
        idle_cycles(1);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_tag_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_tag_q.size() != 0) begin
            err_count++;
            $display("Timeout: done pulse for tag 0x%0h never arrived", exp_tag_q[0]);
            exp_res_q.delete();
            exp_tag_q.delete();
            exp_pc_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        int dones;
        reset       = 1'b1;
        start       = 1'b0;
        a           = '0;
        b           = '0;
        div_op      = DIV_OP_DIVU;
        tag_in      = '0;
        pc_in       = '0;
        err_count   = 0;
        check_count = 0;
        done_count  = 0;
        seed        = 32'hcf5fb084;
        gap         = $urandom(seed);
        $readmemh("verification/div_golden.txt", golden_mem);
        if ($isunknown(golden_mem[NUM_VECS-1])) begin
            err_count++;
            $display("golden vectors did not load from verification/div_golden.txt");
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        errs = err_count;
        for (int i = 0; i < IDLE_CHECK; i++) begin
            @(negedge clk);
            compare_value("done", done, 1'b0);
        end
        report_test("idle after reset", errs);

        errs = err_count;
        send_range(UNS_FIRST, UNS_LAST);
        wait_drain();
        report_test("unsigned back to back", errs);

        errs = err_count;
        send_range(SGN_FIRST, SGN_LAST);
        wait_drain();
        report_test("signed divide and remainder", errs);

        errs = err_count;
        send_range(DBZ_FIRST, DBZ_LAST);
        wait_drain();
        report_test("divide by zero", errs);

        // all four opcodes with random idle gaps
        errs  = err_count;
        dones = done_count;
        for (int i = 0; i < NUM_VECS; i++) begin
            send_vector(i);
            gap = $urandom % 4;
            idle_cycles(gap);
        end
        idle_cycles(1);
        wait_drain();
        idle_cycles(5);
        compare_value("done count", done_count - dones, NUM_VECS);
        report_test("random gap stream", errs);

        $display("tests 5, checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/div_pkg.sv
hw/div_operand_prep.sv
hw/div_restoring_array.sv
hw/div_result_fixup.sv
hw/div_unit.sv
verification/div_unit_tb.sv

// ==== verification/div_golden.txt ====
// columns: op_a_b_tag_pc_expected, all hex, fields split by underscores
// op 1 div, 2 divu, 3 rem, 4 remu, other codes decode as divu
// unsigned
2_00000007_00000002_20_00400000_00000003
4_00000007_00000002_21_00400004_00000001
2_00000064_00000007_22_00400008_0000000e
4_00000064_00000007_23_0040000c_00000002
2_ffffffff_00000001_24_00400010_ffffffff
4_ffffffff_00000010_25_00400014_0000000f
2_80000000_00000003_26_00400018_2aaaaaaa
4_80000000_00000003_27_0040001c_00000002
2_00000005_00000009_28_00400020_00000000
2_12345678_00001000_29_00400024_00012345
0_000000c8_0000000a_2a_00400028_00000014
4_12345678_00001000_2b_0040002c_00000678
// signed, every sign combination
1_00000007_00000002_2c_00400030_00000003
1_fffffff9_00000002_2d_00400034_fffffffd
1_00000007_fffffffe_2e_00400038_fffffffd
1_fffffff9_fffffffe_2f_0040003c_00000003
3_00000007_00000002_30_00400040_00000001
3_fffffff9_00000002_31_00400044_ffffffff
3_00000007_fffffffe_32_00400048_00000001
3_fffffff9_fffffffe_33_0040004c_ffffffff
// most negative by minus one
1_80000000_ffffffff_34_00400050_80000000
3_80000000_ffffffff_35_00400054_00000000
1_ffffff9c_00000007_36_00400058_fffffff2
3_ffffff9c_00000007_37_0040005c_fffffffe
1_80000000_00000002_38_00400060_c0000000
// divide by zero
2_00001234_00000000_39_00400064_ffffffff
4_00001234_00000000_3a_00400068_00001234
1_fffffff9_00000000_3b_0040006c_ffffffff
3_fffffff9_00000000_3c_00400070_fffffff9
1_80000000_00000000_3d_00400074_ffffffff
3_00000000_00000000_3e_00400078_00000000
